/* logic/zx_pkg.sv */
package zx_pkg;

	// extended ports, all on one low byte
	localparam logic [7:0] PORT_XT_LO      = 8'hAF;
	localparam logic [7:0] PORT_PAGE0_HI   = 8'h10;
	localparam logic [7:0] PORT_PAGE1_HI   = 8'h11;
	localparam logic [7:0] PORT_PAGE2_HI   = 8'h12;
	localparam logic [7:0] PORT_PAGE3_HI   = 8'h13;
	localparam logic [7:0] PORT_SYSCONF_HI = 8'h20;
	localparam logic [7:0] PORT_MEMCONF_HI = 8'h21;

	// classic ports, low byte only
	localparam logic [7:0] PORT_FE_LO    = 8'hFE;
	localparam logic [7:0] PORT_COVOX_LO = 8'hFB;
	localparam int         FE_BEEP_BIT   = 4;

	// config register bits
	localparam int MEMCONF_W0_WE    = 1;
	localparam int MEMCONF_W0_RAM   = 3;
	localparam int SYSCONF_COVOX_EN = 2;

	localparam int PAGE_W  = 8;
	localparam int ROMPG_W = 5;

	localparam logic [7:0]        MEMCONF_RST = 8'h00;
	localparam logic [7:0]        SYSCONF_RST = 8'h00;
	localparam logic [PAGE_W-1:0] PAGE_RST0   = 8'd0;
	localparam logic [PAGE_W-1:0] PAGE_RST1   = 8'd5;
	localparam logic [PAGE_W-1:0] PAGE_RST2   = 8'd2;
	localparam logic [PAGE_W-1:0] PAGE_RST3   = 8'd0;

	// maskable interrupt timing, in fclk cycles
	localparam int INT_PERIOD = 256;
	localparam int INT_LEN    = 32;
	localparam int INT_CNT_W  = $clog2(INT_PERIOD);
	localparam int INT_LEN_W  = $clog2(INT_LEN);

	// z80 address seen as an i/o port or as a memory window
	typedef union packed {
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} port;
		struct packed {
			logic [1:0]  win;
			logic [13:0] ofs;
		} mem;
	} zaddr_u;

endpackage

/* logic/zsignals.sv */
`timescale 1ns/1ps

module zsignals (
	input  logic fclk,
	input  logic arst_n,
	input  logic iorq_n,
	input  logic mreq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	output logic iord,
	output logic iowr,
	output logic iowr_s,
	output logic mreq,
	output logic memrd,
	output logic memwr,
	output logic intack,
	output logic intack_s
);

	// order: iorq, mreq, rd, wr, m1 (active high)
	logic [4:0] raw;
	logic [4:0] sync_1;
	logic [4:0] sync_2;
	logic       iorq;
	logic       rd;
	logic       wr;
	logic       m1;
	logic       iowr_d;
	logic       intack_d;

	assign raw = ~{iorq_n, mreq_n, rd_n, wr_n, m1_n};

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
		end else begin
			sync_1 <= raw;
			sync_2 <= sync_1;
		end
	end

	assign {iorq, mreq, rd, wr, m1} = sync_2;

	// bus cycle levels
	assign iord   = iorq & rd & ~m1;
	assign iowr   = iorq & wr;
	assign memrd  = mreq & rd;
	assign memwr  = mreq & wr;
	assign intack = iorq & m1;

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			iowr_d   <= 1'b0;
			intack_d <= 1'b0;
		end else begin
			iowr_d   <= iowr;
			intack_d <= intack;
		end
	end

	// one cycle on the rising edge of the level
	assign iowr_s   = iowr & ~iowr_d;
	assign intack_s = intack & ~intack_d;

endmodule

/* logic/zports.sv */
`timescale 1ns/1ps

module zports (
	input  logic                      fclk,
	input  logic                      arst_n,
	input  zx_pkg::zaddr_u            a,
	input  logic [7:0]                d,
	input  logic                      iord,
	input  logic                      iowr_s,
	output logic [7:0]                memconf,
	output logic [zx_pkg::PAGE_W-1:0] xt_page0,
	output logic [zx_pkg::PAGE_W-1:0] xt_page1,
	output logic [zx_pkg::PAGE_W-1:0] xt_page2,
	output logic [zx_pkg::PAGE_W-1:0] xt_page3,
	output logic [7:0]                sysconf,
	output logic [2:0]                border,
	output logic [7:0]                zd_out,
	output logic                      zd_ena,
	output logic                      beeper_wr,
	output logic                      covox_wr
);

	import zx_pkg::*;

	logic       xt_hit;
	logic       fe_hit;
	logic       fb_hit;
	logic       hi_hit;
	logic       rd_hit;
	logic [7:0] rd_data;

	assign xt_hit = (a.port.lo == PORT_XT_LO);
	assign fe_hit = (a.port.lo == PORT_FE_LO);
	assign fb_hit = (a.port.lo == PORT_COVOX_LO);

	//////////////////////////////
	// write side
	//////////////////////////////

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			memconf  <= MEMCONF_RST;
			sysconf  <= SYSCONF_RST;
			xt_page0 <= PAGE_RST0;
			xt_page1 <= PAGE_RST1;
			xt_page2 <= PAGE_RST2;
			xt_page3 <= PAGE_RST3;
			border   <= 3'd0;
		end else if (iowr_s) begin
			if (xt_hit) begin
				case (a.port.hi)
					PORT_PAGE0_HI:   xt_page0 <= d;
					PORT_PAGE1_HI:   xt_page1 <= d;
					PORT_PAGE2_HI:   xt_page2 <= d;
					PORT_PAGE3_HI:   xt_page3 <= d;
					PORT_SYSCONF_HI: sysconf  <= d;
					PORT_MEMCONF_HI: memconf  <= d;
					default: ;
				endcase
			end
			if (fe_hit)
				border <= d[2:0];
		end
	end

	// sound latches sit in the sound block
	assign beeper_wr = iowr_s & fe_hit;
	assign covox_wr  = iowr_s & fb_hit;

	//////////////////////////////
	// read side
	//////////////////////////////

	always_comb begin
		hi_hit  = 1'b1;
		rd_data = 8'hFF;
		case (a.port.hi)
			PORT_PAGE0_HI:   rd_data = xt_page0;
			PORT_PAGE1_HI:   rd_data = xt_page1;
			PORT_PAGE2_HI:   rd_data = xt_page2;
			PORT_PAGE3_HI:   rd_data = xt_page3;
			PORT_SYSCONF_HI: rd_data = sysconf;
			PORT_MEMCONF_HI: rd_data = memconf;
			default:         hi_hit  = 1'b0;
		endcase
	end

	assign rd_hit = xt_hit & hi_hit;

	// idle bus reads as ff
	assign zd_out = rd_hit ? rd_data : 8'hFF;
	assign zd_ena = iord & rd_hit;

endmodule

/* logic/zmem.sv */
`timescale 1ns/1ps

module zmem (
	input  zx_pkg::zaddr_u             a,
	input  logic [7:0]                 memconf,
	input  logic [zx_pkg::PAGE_W-1:0]  xt_page0,
	input  logic [zx_pkg::PAGE_W-1:0]  xt_page1,
	input  logic [zx_pkg::PAGE_W-1:0]  xt_page2,
	input  logic [zx_pkg::PAGE_W-1:0]  xt_page3,
	input  logic                       mreq,
	input  logic                       memrd,
	input  logic                       memwr,
	output logic                       csrom,
	output logic                       romoe_n,
	output logic                       romwe_n,
	output logic [zx_pkg::ROMPG_W-1:0] rompg,
	output logic                       ram_cs,
	output logic [zx_pkg::PAGE_W-1:0]  ram_page
);

	import zx_pkg::*;

	logic [PAGE_W-1:0] page;
	logic              rom_sel;

	// page of the addressed 16k window
	always_comb begin
		case (a.mem.win)
			2'd0:    page = xt_page0;
			2'd1:    page = xt_page1;
			2'd2:    page = xt_page2;
			default: page = xt_page3;
		endcase
	end

	// only window 0 can hold rom
	assign rom_sel = (a.mem.win == 2'd0) && !memconf[MEMCONF_W0_RAM];

	assign csrom   = rom_sel & mreq;
	assign romoe_n = ~(rom_sel & memrd);
	assign romwe_n = ~(rom_sel & memwr & memconf[MEMCONF_W0_WE]);
	assign rompg   = page[ROMPG_W-1:0];

	assign ram_cs   = ~rom_sel & mreq;
	assign ram_page = page;

endmodule

/* logic/zint.sv */
`timescale 1ns/1ps

module zint (
	input  logic fclk,
	input  logic arst_n,
	input  logic intack_s,
	output logic int_n
);

	import zx_pkg::*;

	logic [INT_CNT_W-1:0] frame_cnt;
	logic [INT_LEN_W-1:0] len_cnt;
	logic                 frame_wrap;
	logic                 int_act;

	assign frame_wrap = (frame_cnt == INT_CNT_W'(INT_PERIOD - 1));

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt <= '0;
			len_cnt   <= '0;
			int_act   <= 1'b0;
		end else begin
			frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
			// new frame wins over a pending ack
			if (frame_wrap) begin
				int_act <= 1'b1;
				len_cnt <= '0;
			end else if (int_act) begin
				if (intack_s || len_cnt == INT_LEN_W'(INT_LEN - 1))
					int_act <= 1'b0;
				len_cnt <= len_cnt + 1'b1;
			end
		end
	end

	assign int_n = ~int_act;

endmodule

/* logic/sound.sv */
`timescale 1ns/1ps

module sound (
	input  logic       fclk,
	input  logic       arst_n,
	input  logic [7:0] d,
	input  logic       beeper_wr,
	input  logic       covox_wr,
	input  logic       covox_en,
	output logic       beep
);

	import zx_pkg::*;

	logic       beep_bit;
	logic [7:0] sample;
	logic [7:0] acc;
	logic [8:0] sum;
	logic       dac_bit;

	// first order delta-sigma, carry is the output bit
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n) begin
			beep_bit <= 1'b0;
			sample   <= 8'd0;
			acc      <= 8'd0;
			dac_bit  <= 1'b0;
		end else begin
			if (beeper_wr)
				beep_bit <= d[FE_BEEP_BIT];
			if (covox_wr)
				sample <= d;
			acc     <= sum[7:0];
			dac_bit <= sum[8];
		end
	end

	assign beep = covox_en ? dac_bit : beep_bit;

endmodule

/* logic/zx_top.sv */
`timescale 1ns/1ps

module zx_top (
	input  logic                       fclk,
	input  logic                       arst_n,
	input  logic                       iorq_n,
	input  logic                       mreq_n,
	input  logic                       rd_n,
	input  logic                       wr_n,
	input  logic                       m1_n,
	input  logic [15:0]                a,
	input  logic [7:0]                 d,
	output logic [7:0]                 zd_out,
	output logic                       zd_ena,
	output logic                       int_n,
	output logic                       csrom,
	output logic                       romoe_n,
	output logic                       romwe_n,
	output logic [zx_pkg::ROMPG_W-1:0] rompg,
	output logic                       ram_cs,
	output logic [zx_pkg::PAGE_W-1:0]  ram_page,
	output logic [2:0]                 border,
	output logic                       beep
);

	import zx_pkg::*;

	zaddr_u            za;
	logic              iord;
	logic              iowr_s;
	logic              mreq;
	logic              memrd;
	logic              memwr;
	logic              intack_s;
	logic [7:0]        memconf;
	logic [7:0]        sysconf;
	logic [PAGE_W-1:0] xt_page0;
	logic [PAGE_W-1:0] xt_page1;
	logic [PAGE_W-1:0] xt_page2;
	logic [PAGE_W-1:0] xt_page3;
	logic              beeper_wr;
	logic              covox_wr;

	assign za = a;

	//////////////////////////////
	// bus strobes
	//////////////////////////////

	zsignals i_zsignals (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.iord     (iord),
		.iowr     (),
		.iowr_s   (iowr_s),
		.mreq     (mreq),
		.memrd    (memrd),
		.memwr    (memwr),
		.intack   (),
		.intack_s (intack_s)
	);

	zports i_zports (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.a         (za),
		.d         (d),
		.iord      (iord),
		.iowr_s    (iowr_s),
		.memconf   (memconf),
		.xt_page0  (xt_page0),
		.xt_page1  (xt_page1),
		.xt_page2  (xt_page2),
		.xt_page3  (xt_page3),
		.sysconf   (sysconf),
		.border    (border),
		.zd_out    (zd_out),
		.zd_ena    (zd_ena),
		.beeper_wr (beeper_wr),
		.covox_wr  (covox_wr)
	);

	zmem i_zmem (
		.a        (za),
		.memconf  (memconf),
		.xt_page0 (xt_page0),
		.xt_page1 (xt_page1),
		.xt_page2 (xt_page2),
		.xt_page3 (xt_page3),
		.mreq     (mreq),
		.memrd    (memrd),
		.memwr    (memwr),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.rompg    (rompg),
		.ram_cs   (ram_cs),
		.ram_page (ram_page)
	);

	zint i_zint (
		.fclk     (fclk),
		.arst_n   (arst_n),
		.intack_s (intack_s),
		.int_n    (int_n)
	);

	// covox replaces the beeper when enabled
	sound i_sound (
		.fclk      (fclk),
		.arst_n    (arst_n),
		.d         (d),
		.beeper_wr (beeper_wr),
		.covox_wr  (covox_wr),
		.covox_en  (sysconf[SYSCONF_COVOX_EN]),
		.beep      (beep)
	);

endmodule

/* verif/zx_top_assertions.sv */
`timescale 1ns/1ps

module zx_top_assertions (
	input logic fclk,
	input logic arst_n,
	input logic iorq_n,
	input logic mreq_n,
	input logic rd_n,
	input logic m1_n,
	input logic zd_ena,
	input logic int_n,
	input logic csrom,
	input logic ram_cs
);

	import zx_pkg::*;

	// clocks int_n has been low in a row
	logic [5:0] low_run;

	always_ff @(posedge fclk or negedge arst_n) begin
		if (!arst_n)
			low_run <= 6'd0;
		else
			low_run <= int_n ? 6'd0 : low_run + 6'd1;
	end

	// pins reach the outputs through two synchronizer flops
	zd_ena_needs_iord: assert property (@(posedge fclk) disable iff (!arst_n)
		zd_ena |-> $past(!iorq_n && !rd_n && m1_n, 2))
		else $error("zd_ena high outside an i/o read");

	int_n_max_len: assert property (@(posedge fclk) disable iff (!arst_n)
		low_run <= 6'(INT_LEN))
		else $error("int_n low longer than INT_LEN");

	rom_ram_exclusive: assert property (@(posedge fclk) disable iff (!arst_n)
		!(csrom && ram_cs) && ((csrom || ram_cs) == $past(!mreq_n, 2)))
		else $error("csrom and ram_cs both high or not following the memory request");

endmodule

bind zx_top zx_top_assertions i_zx_top_assertions (
	.fclk   (fclk),
	.arst_n (arst_n),
	.iorq_n (iorq_n),
	.mreq_n (mreq_n),
	.rd_n   (rd_n),
	.m1_n   (m1_n),
	.zd_ena (zd_ena),
	.int_n  (int_n),
	.csrom  (csrom),
	.ram_cs (ram_cs)
);

/* verif/tb_zx_top.sv */
`timescale 1ns/1ps

module tb_zx_top;

	import zx_pkg::*;

	localparam int N_RAND  = 600;
	localparam int N_COVOX = 4;
	localparam int N_ACK   = 3;
	// random phase at 8 clocks per bus cycle, plus room for the fixed phases
	localparam int MAX_CYCLES = N_RAND * 8 + 4000;

	logic                fclk;
	logic                arst_n;
	logic                iorq_n;
	logic                mreq_n;
	logic                rd_n;
	logic                wr_n;
	logic                m1_n;
	logic [15:0]         a;
	logic [7:0]          d;
	logic [7:0]          zd_out;
	logic                zd_ena;
	logic                int_n;
	logic                csrom;
	logic                romoe_n;
	logic                romwe_n;
	logic [ROMPG_W-1:0]  rompg;
	logic                ram_cs;
	logic [PAGE_W-1:0]   ram_page;
	logic [2:0]          border;
	logic                beep;

	// reference model
	logic [7:0]          m_memconf = MEMCONF_RST;
	logic [7:0]          m_sysconf = SYSCONF_RST;
	logic [PAGE_W-1:0]   m_page [4] = '{PAGE_RST0, PAGE_RST1, PAGE_RST2, PAGE_RST3};
	logic [2:0]          m_border = 3'd0;
	logic                m_beep = 1'b0;
	logic [7:0]          m_sample = 8'd0;
	logic [7:0]          xt_hi [6] = '{PORT_PAGE0_HI, PORT_PAGE1_HI, PORT_PAGE2_HI,
		PORT_PAGE3_HI, PORT_SYSCONF_HI, PORT_MEMCONF_HI};

	int   cycle_cnt = 0;
	int   last_fall = 0;
	int   low_cnt = 0;
	int   acks_issued = 0;
	int   acks_handled = 0;
	bit   seen_fall = 1'b0;
	logic int_prev = 1'b1;

	zx_top i_zx_top (.*);

	initial begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

	always @(posedge fclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic xt_readable(input logic [15:0] addr);
		return addr[7:0] == PORT_XT_LO && (addr[15:8] inside {PORT_PAGE0_HI, PORT_PAGE1_HI,
			PORT_PAGE2_HI, PORT_PAGE3_HI, PORT_SYSCONF_HI, PORT_MEMCONF_HI});
	endfunction

	function automatic logic [7:0] xt_value(input logic [7:0] hi);
		case (hi)
			PORT_PAGE0_HI:   return m_page[0];
			PORT_PAGE1_HI:   return m_page[1];
			PORT_PAGE2_HI:   return m_page[2];
			PORT_PAGE3_HI:   return m_page[3];
			PORT_SYSCONF_HI: return m_sysconf;
			default:         return m_memconf;
		endcase
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		if (xt_readable(addr)) begin
			case (addr[15:8])
				PORT_PAGE0_HI:   m_page[0] = data;
				PORT_PAGE1_HI:   m_page[1] = data;
				PORT_PAGE2_HI:   m_page[2] = data;
				PORT_PAGE3_HI:   m_page[3] = data;
				PORT_SYSCONF_HI: m_sysconf = data;
				default:         m_memconf = data;
			endcase
		end
		if (addr[7:0] == PORT_FE_LO) begin
			m_border = data[2:0];
			m_beep   = data[4];
		end
		if (addr[7:0] == PORT_COVOX_LO)
			m_sample = data;
	endtask

	task automatic check_outputs(input logic io, input logic wr, input logic [15:0] addr);
		logic [PAGE_W-1:0] page;
		logic              rom;
		logic              hit;
		page = m_page[addr[15:14]];
		rom  = !io && addr[15:14] == 2'd0 && !m_memconf[MEMCONF_W0_RAM];
		hit  = io && !wr && xt_readable(addr);
		compare("border", 32'(border), 32'(m_border));
		if (!m_sysconf[SYSCONF_COVOX_EN])
			compare("beep", 32'(beep), 32'(m_beep));
		compare("csrom", 32'(csrom), 32'(rom));
		compare("romoe_n", 32'(romoe_n), 32'(!(rom && !wr)));
		compare("romwe_n", 32'(romwe_n), 32'(!(rom && wr && m_memconf[MEMCONF_W0_WE])));
		compare("ram_cs", 32'(ram_cs), 32'(!io && !rom));
		if (!io) begin
			compare("rompg", 32'(rompg), 32'(page[ROMPG_W-1:0]));
			compare("ram_page", 32'(ram_page), 32'(page));
		end
		compare("zd_ena", 32'(zd_ena), 32'(hit));
		if (hit)
			compare("zd_out", 32'(zd_out), 32'(xt_value(addr[15:8])));
	endtask

	// 6 clocks of pins, 2 idle, outputs sampled in clock 5
	task automatic bus_cycle(input logic io, input logic wr, input logic ack,
		input logic [15:0] addr, input logic [7:0] data);
		@(posedge fclk);
		iorq_n <= !(io || ack);
		mreq_n <= io || ack;
		rd_n   <= wr || ack;
		wr_n   <= !(wr && !ack);
		m1_n   <= !ack;
		a      <= addr;
		d      <= data;
		repeat (4) @(posedge fclk);
		@(negedge fclk);
		if (ack) begin
			compare("int_n", 32'(int_n), 32'd1);
			compare("zd_ena", 32'(zd_ena), 32'd0);
		end else begin
			if (io && wr)
				model_write(addr, data);
			check_outputs(io, wr, addr);
		end
		repeat (2) @(posedge fclk);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		@(posedge fclk);
	endtask

	function automatic logic [15:0] pick_port();
		logic [31:0] r;
		logic [7:0]  hi;
		logic [7:0]  lo;
		r  = $urandom;
		hi = (r[1:0] != 2'd0) ? xt_hi[r[4:2] % 3'd6] : r[15:8];
		case (r[18:16])
			3'd0, 3'd1, 3'd2, 3'd3: lo = PORT_XT_LO;
			3'd4:                   lo = PORT_FE_LO;
			3'd5:                   lo = PORT_COVOX_LO;
			default:                lo = r[31:24];
		endcase
		return {hi, lo};
	endfunction

	// interrupt spacing and length, skipped for an acknowledged one
	always @(negedge fclk) begin
		if (arst_n) begin
			if (!int_n) begin
				if (int_prev) begin
					if (seen_fall)
						compare("int_n period", 32'(cycle_cnt - last_fall), 32'(INT_PERIOD));
					last_fall = cycle_cnt;
					seen_fall = 1'b1;
					low_cnt   = 1;
				end else begin
					low_cnt = low_cnt + 1;
				end
			end else if (!int_prev) begin
				if (acks_handled == acks_issued)
					compare("int_n low time", 32'(low_cnt), 32'(INT_LEN));
				acks_handled = acks_issued;
			end
			int_prev = int_n;
		end
	end

	initial begin
		logic [31:0] r;
		int          ones;
		void'($urandom(53));
		arst_n = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		a      = 16'h0000;
		d      = 8'h00;
		repeat (2) @(posedge fclk);
		arst_n <= 1'b1;

		//////////////////////////////
		// reset state and readback
		//////////////////////////////
		@(negedge fclk);
		compare("int_n", 32'(int_n), 32'd1);
		compare("beep", 32'(beep), 32'd0);
		check_outputs(1'b1, 1'b1, 16'h0000);
		for (int i = 0; i < 6; i++)
			bus_cycle(1'b1, 1'b0, 1'b0, {xt_hi[i], PORT_XT_LO}, 8'h00);

		// random port and memory cycles
		for (int i = 0; i < N_RAND; i++) begin
			r = $urandom;
			if (r[0])
				bus_cycle(1'b1, r[1], 1'b0, pick_port(), r[15:8]);
			else
				bus_cycle(1'b0, r[1], 1'b0, r[31:16], r[15:8]);
		end

		// beeper path with covox off
		bus_cycle(1'b1, 1'b1, 1'b0, {PORT_SYSCONF_HI, PORT_XT_LO}, 8'h00);
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			bus_cycle(1'b1, 1'b1, 1'b0, {r[31:24], PORT_FE_LO}, r[7:0]);
		end

		//////////////////////////////
		// covox dac density
		//////////////////////////////
		bus_cycle(1'b1, 1'b1, 1'b0, {PORT_SYSCONF_HI, PORT_XT_LO}, 8'h04);
		for (int i = 0; i < N_COVOX; i++) begin
			r = $urandom;
			bus_cycle(1'b1, 1'b1, 1'b0, {r[31:24], PORT_COVOX_LO}, r[7:0]);
			ones = 0;
			repeat (256) begin
				@(negedge fclk);
				if (beep)
					ones = ones + 1;
			end
			compare("beep high count", 32'(ones), 32'(m_sample));
		end

		// acknowledge right after the interrupt starts
		for (int i = 0; i < N_ACK; i++) begin
			@(negedge fclk);
			while (!int_n)
				@(negedge fclk);
			while (int_n)
				@(negedge fclk);
			acks_issued = acks_issued + 1;
			bus_cycle(1'b0, 1'b0, 1'b1, 16'h0000, 8'hFF);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* list.f */
logic/zx_pkg.sv
logic/zsignals.sv
logic/zports.sv
logic/zmem.sv
logic/zint.sv
logic/sound.sv
logic/zx_top.sv
verif/zx_top_assertions.sv
verif/tb_zx_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the zx_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_zx_top \
	-Mdir obj_dir \
	-f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_zx_top
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0
